/* Makefile */
# Verilator flow for the data memory subsystem

VERILATOR  ?= verilator
FILELIST   ?= vlog.f
TB_TOP     ?= tb_dmem_subsys
RTL_TOP    ?= dmem_subsys_top
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/10ps
VFLAGS     ?=
PASS_TEXT  ?= Test passed

SIM_BIN = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) \
		-f $(FILELIST) --top-module $(RTL_TOP) $(VFLAGS)

build:
	$(VERILATOR) --binary --timing --timescale $(TIMESCALE) \
		-f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP) $(VFLAGS)

sim: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
		echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* hdl/dmem_cfg.svh */
`ifndef DMEM_CFG_SVH
`define DMEM_CFG_SVH

// ----------------------------------------------------------
// Data path widths
// ----------------------------------------------------------
`define DMEM_AWIDTH         32              // Byte address
`define DMEM_DWIDTH         32              // Data word

// ----------------------------------------------------------
// Timer window in the data address map
// ----------------------------------------------------------
`define TIMER_ADDR_MASK     32'hFFFF_FFE0   // 32-byte window
`define TIMER_ADDR_PATTERN  32'hF004_0000   // Window base

// Register offsets inside the window
`define TIMER_OFS_CTRL      5'h00           // Bit 0 enables counting
`define TIMER_OFS_DIV       5'h04           // Prescaler reload
`define TIMER_OFS_MTIME_LO  5'h08
`define TIMER_OFS_MTIME_HI  5'h0C
`define TIMER_OFS_CMP_LO    5'h10
`define TIMER_OFS_CMP_HI    5'h14

// Prescaler
`define TIMER_DIV_WIDTH     10              // Divider register width

`endif

/* hdl/dmem_if_pkg.sv */
`include "dmem_cfg.svh"

package dmem_if_pkg;

    // ----------------------------------------------------------
    // Core-side payload types
    // ----------------------------------------------------------
    typedef logic [`DMEM_AWIDTH-1:0]   mem_addr_t;   // Byte address
    typedef logic [`DMEM_DWIDTH-1:0]   mem_data_t;   // One data word
    typedef logic [2*`DMEM_DWIDTH-1:0] mtime_t;      // 64-bit timer value

    // Transfer direction
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    // Access size
    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10
    } mem_width_e;

    // Response code, one cycle of RDY_* per request
    typedef enum logic [1:0] {
        MEM_RESP_NOTRDY = 2'b00,   // Idle or waiting
        MEM_RESP_RDY_OK = 2'b01,   // Done
        MEM_RESP_RDY_ER = 2'b10    // Done with error
    } mem_resp_e;

endpackage : dmem_if_pkg

/* hdl/dmem_router.sv */
`timescale 1ns/10ps
`include "dmem_cfg.svh"

module dmem_router import dmem_if_pkg::*; (
    input  logic       core_clk_i,
    input  logic       reset_i,
    // Core side
    input  logic       dmem_req_i,
    input  mem_cmd_e   dmem_cmd_i,
    input  mem_width_e dmem_width_i,
    input  mem_addr_t  dmem_addr_i,
    input  mem_data_t  dmem_wdata_i,
    output logic       dmem_req_ack_o,
    output mem_data_t  dmem_rdata_o,
    output mem_resp_e  dmem_resp_o,
    // Timer port
    output logic       tmr_req_o,
    output mem_cmd_e   tmr_cmd_o,
    output mem_width_e tmr_width_o,
    output mem_addr_t  tmr_addr_o,
    output mem_data_t  tmr_wdata_o,
    input  logic       tmr_req_ack_i,
    input  mem_data_t  tmr_rdata_i,
    input  mem_resp_e  tmr_resp_i,
    // Wishbone bridge port
    output logic       wb_req_o,
    output mem_cmd_e   wb_cmd_o,
    output mem_width_e wb_width_o,
    output mem_addr_t  wb_addr_o,
    output mem_data_t  wb_wdata_o,
    input  logic       wb_req_ack_i,
    input  mem_data_t  wb_rdata_i,
    input  mem_resp_e  wb_resp_i
);

logic      tmr_hit;      // Address falls in timer window
logic      pending_q;    // A request is in flight
logic      sel_tmr_q;    // Port of the request in flight
mem_resp_e resp_sel;     // Response of the port in flight
mem_data_t rdata_sel;
logic      resp_done;    // In-flight request completes this cycle
logic      can_issue;    // Router free to pass a new request
logic      port_ack;
logic      accept;

// ----------------------------------------------------------
// Address decode
// ----------------------------------------------------------
assign tmr_hit = ((dmem_addr_i & `TIMER_ADDR_MASK) == `TIMER_ADDR_PATTERN);

// Response path follows the registered port
assign resp_sel  = sel_tmr_q ? tmr_resp_i  : wb_resp_i;
assign rdata_sel = sel_tmr_q ? tmr_rdata_i : wb_rdata_i;
assign resp_done = pending_q & (resp_sel != MEM_RESP_NOTRDY);

// Free when idle, or in the cycle the old response returns
assign can_issue = ~pending_q | resp_done;
assign port_ack  = tmr_hit ? tmr_req_ack_i : wb_req_ack_i;

assign dmem_req_ack_o = can_issue & port_ack;
assign accept         = dmem_req_i & dmem_req_ack_o;

// ----------------------------------------------------------
// Request fan-out
// ----------------------------------------------------------
assign tmr_req_o   = dmem_req_i & can_issue & tmr_hit;   // Only one port sees req
assign tmr_cmd_o   = dmem_cmd_i;
assign tmr_width_o = dmem_width_i;
assign tmr_addr_o  = dmem_addr_i;
assign tmr_wdata_o = dmem_wdata_i;

assign wb_req_o    = dmem_req_i & can_issue & ~tmr_hit;
assign wb_cmd_o    = dmem_cmd_i;
assign wb_width_o  = dmem_width_i;
assign wb_addr_o   = dmem_addr_i;
assign wb_wdata_o  = dmem_wdata_i;

// ----------------------------------------------------------
// Outstanding request tracking
// ----------------------------------------------------------
always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
        pending_q <= 1'b0;
        sel_tmr_q <= 1'b0;
    end else if (accept) begin
        pending_q <= 1'b1;       // Back-to-back also lands here
        sel_tmr_q <= tmr_hit;
    end else if (resp_done) begin
        pending_q <= 1'b0;
    end
end

// Core sees NOTRDY unless a request is in flight
assign dmem_resp_o  = pending_q ? resp_sel : MEM_RESP_NOTRDY;
assign dmem_rdata_o = rdata_sel;

endmodule : dmem_router

/* hdl/dmem_subsys_top.sv */
`timescale 1ns/10ps

module dmem_subsys_top import dmem_if_pkg::*, wb_pkg::*; (
    input  logic       core_clk_i,
    input  logic       reset_i,
    // Core data port
    input  logic       dmem_req_i,
    input  mem_cmd_e   dmem_cmd_i,
    input  mem_width_e dmem_width_i,
    input  mem_addr_t  dmem_addr_i,
    input  mem_data_t  dmem_wdata_i,
    output logic       dmem_req_ack_o,
    output mem_data_t  dmem_rdata_o,
    output mem_resp_e  dmem_resp_o,
    // Wishbone
    output logic       wb_stb_o,
    output mem_addr_t  wb_adr_o,
    output logic       wb_we_o,
    output mem_data_t  wb_dat_o,
    output wb_sel_t    wb_sel_o,
    input  mem_data_t  wb_dat_i,
    input  logic       wb_ack_i,
    input  logic       wb_err_i,
    // Timer
    output logic       timer_irq_o,
    output mtime_t     mtime_o
);

// Router to timer
logic       tmr_req;
mem_cmd_e   tmr_cmd;
mem_width_e tmr_width;
mem_addr_t  tmr_addr;
mem_data_t  tmr_wdata;
logic       tmr_req_ack;
mem_data_t  tmr_rdata;
mem_resp_e  tmr_resp;

// Router to bridge
logic       br_req;
mem_cmd_e   br_cmd;
mem_width_e br_width;
mem_addr_t  br_addr;
mem_data_t  br_wdata;
logic       br_req_ack;
mem_data_t  br_rdata;
mem_resp_e  br_resp;

// ----------------------------------------------------------
// Address router
// ----------------------------------------------------------
dmem_router u_router (
    .core_clk_i     (core_clk_i    ),
    .reset_i        (reset_i       ),
    .dmem_req_i     (dmem_req_i    ),
    .dmem_cmd_i     (dmem_cmd_i    ),
    .dmem_width_i   (dmem_width_i  ),
    .dmem_addr_i    (dmem_addr_i   ),
    .dmem_wdata_i   (dmem_wdata_i  ),
    .dmem_req_ack_o (dmem_req_ack_o),
    .dmem_rdata_o   (dmem_rdata_o  ),
    .dmem_resp_o    (dmem_resp_o   ),
    .tmr_req_o      (tmr_req       ),
    .tmr_cmd_o      (tmr_cmd       ),
    .tmr_width_o    (tmr_width     ),
    .tmr_addr_o     (tmr_addr      ),
    .tmr_wdata_o    (tmr_wdata     ),
    .tmr_req_ack_i  (tmr_req_ack   ),
    .tmr_rdata_i    (tmr_rdata     ),
    .tmr_resp_i     (tmr_resp      ),
    .wb_req_o       (br_req        ),
    .wb_cmd_o       (br_cmd        ),
    .wb_width_o     (br_width      ),
    .wb_addr_o      (br_addr       ),
    .wb_wdata_o     (br_wdata      ),
    .wb_req_ack_i   (br_req_ack    ),
    .wb_rdata_i     (br_rdata      ),
    .wb_resp_i      (br_resp       )
);

// ----------------------------------------------------------
// Machine timer
// ----------------------------------------------------------
mtimer u_mtimer (
    .core_clk_i  (core_clk_i ),
    .reset_i     (reset_i    ),
    .req_i       (tmr_req    ),
    .cmd_i       (tmr_cmd    ),
    .width_i     (tmr_width  ),
    .addr_i      (tmr_addr   ),
    .wdata_i     (tmr_wdata  ),
    .req_ack_o   (tmr_req_ack),
    .rdata_o     (tmr_rdata  ),
    .resp_o      (tmr_resp   ),
    .timer_irq_o (timer_irq_o),
    .mtime_o     (mtime_o    )
);

// ----------------------------------------------------------
// Wishbone bridge
// ----------------------------------------------------------
dmem_wb_bridge u_wb_bridge (
    .core_clk_i (core_clk_i),
    .reset_i    (reset_i   ),
    .req_i      (br_req    ),
    .cmd_i      (br_cmd    ),
    .width_i    (br_width  ),
    .addr_i     (br_addr   ),
    .wdata_i    (br_wdata  ),
    .req_ack_o  (br_req_ack),
    .rdata_o    (br_rdata  ),
    .resp_o     (br_resp   ),
    .wb_stb_o   (wb_stb_o  ),
    .wb_adr_o   (wb_adr_o  ),
    .wb_we_o    (wb_we_o   ),
    .wb_dat_o   (wb_dat_o  ),
    .wb_sel_o   (wb_sel_o  ),
    .wb_dat_i   (wb_dat_i  ),
    .wb_ack_i   (wb_ack_i  ),
    .wb_err_i   (wb_err_i  )
);

endmodule : dmem_subsys_top

/* hdl/dmem_wb_bridge.sv */
`timescale 1ns/10ps

module dmem_wb_bridge import dmem_if_pkg::*, wb_pkg::*; (
    input  logic       core_clk_i,
    input  logic       reset_i,
    // Request from router
    input  logic       req_i,
    input  mem_cmd_e   cmd_i,
    input  mem_width_e width_i,
    input  mem_addr_t  addr_i,
    input  mem_data_t  wdata_i,
    output logic       req_ack_o,
    output mem_data_t  rdata_o,
    output mem_resp_e  resp_o,
    // Wishbone master
    output logic       wb_stb_o,
    output mem_addr_t  wb_adr_o,
    output logic       wb_we_o,
    output mem_data_t  wb_dat_o,
    output wb_sel_t    wb_sel_o,
    input  mem_data_t  wb_dat_i,
    input  logic       wb_ack_i,
    input  logic       wb_err_i
);

wb_state_e state_q;
logic      accept;
logic      wb_done;      // Slave ended the cycle
wb_sel_t   sel_nxt;
mem_addr_t adr_q;
mem_data_t dat_q;
logic      we_q;
wb_sel_t   sel_q;
mem_data_t rdata_q;
logic      err_q;

// Ready in idle and in the response cycle
assign req_ack_o = (state_q != WB_BUSY);
assign accept    = req_i & req_ack_o;
assign wb_done   = (state_q == WB_BUSY) & (wb_ack_i | wb_err_i);

// ----------------------------------------------------------
// Byte lane select
// ----------------------------------------------------------
always_comb begin
    case (width_i)
        MEM_WIDTH_BYTE:  sel_nxt = wb_sel_t'(4'b0001 << addr_i[1:0]);
        MEM_WIDTH_HWORD: sel_nxt = addr_i[1] ? 4'b1100 : 4'b0011;   // Upper or lower half
        default:         sel_nxt = '1;                              // Full word
    endcase
end

// ----------------------------------------------------------
// Bridge FSM
// ----------------------------------------------------------
always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
        state_q <= WB_IDLE;
    end else begin
        case (state_q)
            WB_IDLE: if (accept) state_q <= WB_BUSY;
            WB_BUSY: if (wb_done) state_q <= WB_RESP;
            WB_RESP: state_q <= accept ? WB_BUSY : WB_IDLE;   // Back-to-back allowed
            default: state_q <= WB_IDLE;
        endcase
    end
end

// Request latch
always_ff @(posedge core_clk_i) begin
    if (accept) begin
        adr_q <= addr_i;
        dat_q <= wdata_i;
        we_q  <= (cmd_i == MEM_CMD_WR);
        sel_q <= sel_nxt;
    end
end

// Slave answer
always_ff @(posedge core_clk_i) begin
    if (wb_done) begin
        rdata_q <= wb_dat_i;
        err_q   <= wb_err_i;
    end
end

// ----------------------------------------------------------
// Outputs
// ----------------------------------------------------------
assign wb_stb_o = (state_q == WB_BUSY);
assign wb_we_o  = wb_stb_o & we_q;       // Low outside a cycle
assign wb_adr_o = adr_q;
assign wb_dat_o = dat_q;
assign wb_sel_o = sel_q;

assign rdata_o = rdata_q;
assign resp_o  = (state_q != WB_RESP) ? MEM_RESP_NOTRDY :
                 err_q                ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;

endmodule : dmem_wb_bridge

/* hdl/mtimer.sv */
`timescale 1ns/10ps
`include "dmem_cfg.svh"

module mtimer import dmem_if_pkg::*; (
    input  logic       core_clk_i,
    input  logic       reset_i,
    // Register access from router
    input  logic       req_i,
    input  mem_cmd_e   cmd_i,
    input  mem_width_e width_i,
    input  mem_addr_t  addr_i,
    input  mem_data_t  wdata_i,
    output logic       req_ack_o,
    output mem_data_t  rdata_o,
    output mem_resp_e  resp_o,
    // Timer outputs
    output logic       timer_irq_o,
    output mtime_t     mtime_o
);

localparam int DW = `DMEM_DWIDTH;

logic [4:0]                  ofs;          // Offset in 32-byte window
logic                        ofs_valid;
logic                        acc_ok;       // Legal word access
logic                        wr_en;
mem_data_t                   rd_val;
logic                        ctrl_en_q;    // Counting enabled
logic [`TIMER_DIV_WIDTH-1:0] div_q;
logic [`TIMER_DIV_WIDTH-1:0] presc_q;
logic                        tick;         // mtime step
mtime_t                      mtime_q;
mtime_t                      mtimecmp_q;
mem_resp_e                   resp_q;
mem_data_t                   rdata_q;

assign ofs       = addr_i[4:0];
assign req_ack_o = 1'b1;                   // Always ready, single-cycle access

// ----------------------------------------------------------
// Register decode and read mux
// ----------------------------------------------------------
always_comb begin
    ofs_valid = 1'b1;
    rd_val    = '0;
    case (ofs)
        `TIMER_OFS_CTRL:     rd_val = mem_data_t'(ctrl_en_q);
        `TIMER_OFS_DIV:      rd_val = mem_data_t'(div_q);
        `TIMER_OFS_MTIME_LO: rd_val = mtime_q[DW-1:0];
        `TIMER_OFS_MTIME_HI: rd_val = mtime_q[2*DW-1:DW];
        `TIMER_OFS_CMP_LO:   rd_val = mtimecmp_q[DW-1:0];
        `TIMER_OFS_CMP_HI:   rd_val = mtimecmp_q[2*DW-1:DW];
        default:             ofs_valid = 1'b0;   // Hole in the map
    endcase
end

assign acc_ok = req_i & ofs_valid & (width_i == MEM_WIDTH_WORD);
assign wr_en  = acc_ok & (cmd_i == MEM_CMD_WR);

// Control and divider
always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
        ctrl_en_q <= 1'b0;
        div_q     <= '0;
    end else if (wr_en) begin
        if (ofs == `TIMER_OFS_CTRL) ctrl_en_q <= wdata_i[0];
        if (ofs == `TIMER_OFS_DIV)  div_q     <= wdata_i[`TIMER_DIV_WIDTH-1:0];
    end
end

// ----------------------------------------------------------
// Prescaler and counter
// ----------------------------------------------------------
// Step once every div+1 cycles; >= covers a divider lowered mid-count
assign tick = ctrl_en_q & (presc_q >= div_q);

always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
        presc_q <= '0;
    end else if (~ctrl_en_q | tick) begin
        presc_q <= '0;
    end else begin
        presc_q <= presc_q + 1'b1;
    end
end

// Software write wins over the count step
always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
        mtime_q <= '0;
    end else if (wr_en && ofs == `TIMER_OFS_MTIME_LO) begin
        mtime_q[DW-1:0] <= wdata_i;
    end else if (wr_en && ofs == `TIMER_OFS_MTIME_HI) begin
        mtime_q[2*DW-1:DW] <= wdata_i;
    end else if (tick) begin
        mtime_q <= mtime_q + 1'b1;
    end
end

always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
        mtimecmp_q <= '0;
    end else if (wr_en && ofs == `TIMER_OFS_CMP_LO) begin
        mtimecmp_q[DW-1:0] <= wdata_i;
    end else if (wr_en && ofs == `TIMER_OFS_CMP_HI) begin
        mtimecmp_q[2*DW-1:DW] <= wdata_i;
    end
end

// ----------------------------------------------------------
// Response, one cycle after acceptance
// ----------------------------------------------------------
always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
        resp_q <= MEM_RESP_NOTRDY;
    end else if (req_i) begin
        resp_q <= acc_ok ? MEM_RESP_RDY_OK : MEM_RESP_RDY_ER;
    end else begin
        resp_q <= MEM_RESP_NOTRDY;
    end
end

always_ff @(posedge core_clk_i) begin
    if (req_i) rdata_q <= (acc_ok && cmd_i == MEM_CMD_RD) ? rd_val : '0;   // Zero on error
end

assign resp_o  = resp_q;
assign rdata_o = rdata_q;

// Compare of zero means disarmed
assign timer_irq_o = (mtimecmp_q != '0) & (mtime_q >= mtimecmp_q);
assign mtime_o     = mtime_q;

endmodule : mtimer

/* hdl/wb_pkg.sv */
`include "dmem_cfg.svh"

package wb_pkg;

    // One enable per byte lane
    typedef logic [`DMEM_DWIDTH/8-1:0] wb_sel_t;

    // Bridge FSM
    typedef enum logic [1:0] {
        WB_IDLE = 2'b00,   // Ready for a request
        WB_BUSY = 2'b01,   // Strobe out, waiting for ack or err
        WB_RESP = 2'b10    // Response cycle toward the core
    } wb_state_e;

endpackage : wb_pkg

/* tb/tb_dmem_subsys.sv */
`timescale 1ns/10ps
`include "dmem_cfg.svh"

module tb_dmem_subsys import dmem_if_pkg::*, wb_pkg::*; ();

localparam int        CLK_PERIOD      = 4;
localparam int        CYCLES_PER_STEP = 200;
localparam mem_addr_t TMR             = `TIMER_ADDR_PATTERN;
localparam mem_addr_t ERR_MASK        = 32'hFFFF_FF00;   // Slave error window
localparam mem_addr_t ERR_BASE        = 32'hE000_0000;
localparam mtime_t    CMP_TARGET      = 64'd20;
localparam int        AFTER_COUNT     = 1;               // Watch mtime and irq
localparam int        AFTER_IRQ_LOW   = 2;
localparam mem_cmd_e   RD = MEM_CMD_RD;
localparam mem_cmd_e   WR = MEM_CMD_WR;
localparam mem_width_e BY = MEM_WIDTH_BYTE;
localparam mem_width_e HW = MEM_WIDTH_HWORD;
localparam mem_width_e WD = MEM_WIDTH_WORD;
localparam mem_resp_e  OK = MEM_RESP_RDY_OK;
localparam mem_resp_e  ER = MEM_RESP_RDY_ER;

typedef struct {
    string      name;
    mem_cmd_e   cmd;
    mem_width_e width;
    mem_addr_t  addr;
    mem_data_t  wdata;
    wb_sel_t    sel;      // Expected lanes, zero for timer entries
    mem_resp_e  resp;
    mem_data_t  rdata;
    int         after;    // Follow-up action, 0 for none
} step_t;

logic       clk;
logic       rst;
logic       dmem_req;
mem_cmd_e   dmem_cmd;
mem_width_e dmem_width;
mem_addr_t  dmem_addr;
mem_data_t  dmem_wdata;
logic       dmem_req_ack;
mem_data_t  dmem_rdata;
mem_resp_e  dmem_resp;
logic       wb_stb;
mem_addr_t  wb_adr;
logic       wb_we;
mem_data_t  wb_dat_o;
wb_sel_t    wb_sel;
mem_data_t  wb_dat_i;
logic       wb_ack;
logic       wb_err;
logic       timer_irq;
mtime_t     mtime;

step_t      steps[$];
logic [31:0] lcg_state = 32'ha48e;
mem_data_t  wb_mem [16];    // Slave word memory
int         slow_wait = -1; // Forced slave wait, -1 for random
int         last_wait;
mem_addr_t  cur_addr;       // What the slave should see
logic       cur_we;
mem_data_t  cur_wdata;
wb_sel_t    cur_sel;

dmem_subsys_top u_dut (
    .core_clk_i(clk), .reset_i(rst),
    .dmem_req_i(dmem_req), .dmem_cmd_i(dmem_cmd), .dmem_width_i(dmem_width),
    .dmem_addr_i(dmem_addr), .dmem_wdata_i(dmem_wdata), .dmem_req_ack_o(dmem_req_ack),
    .dmem_rdata_o(dmem_rdata), .dmem_resp_o(dmem_resp),
    .wb_stb_o(wb_stb), .wb_adr_o(wb_adr), .wb_we_o(wb_we), .wb_dat_o(wb_dat_o),
    .wb_sel_o(wb_sel), .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack), .wb_err_i(wb_err),
    .timer_irq_o(timer_irq), .mtime_o(mtime)
);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
end

// ----------------------------------------------------------
// Helpers
// ----------------------------------------------------------
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
        $display("FAIL %s: expected %h, actual %h", name, exp, act);
        $display("Test failed");
        $fatal(1);
    end
endtask

task automatic add_step(input string name, input mem_cmd_e cmd, input mem_width_e width,
                        input mem_addr_t addr, input mem_data_t wdata, input wb_sel_t sel,
                        input mem_resp_e resp, input mem_data_t rdata, input int after);
    step_t s;
    s = '{name, cmd, width, addr, wdata, sel, resp, rdata, after};
    steps.push_back(s);
endtask

task automatic drive_req(input mem_cmd_e cmd, input mem_width_e width,
                         input mem_addr_t addr, input mem_data_t wdata);
    dmem_req   = 1'b1;
    dmem_cmd   = cmd;
    dmem_width = width;
    dmem_addr  = addr;
    dmem_wdata = wdata;
endtask

// ----------------------------------------------------------
// Wishbone slave model, acts on falling edges
// ----------------------------------------------------------
initial begin : wb_slave
    int   cnt;
    logic busy;
    busy     = 1'b0;
    cnt      = 0;
    wb_ack   = 1'b0;
    wb_err   = 1'b0;
    wb_dat_i = '0;
    for (int i = 0; i < 16; i++) wb_mem[i] = 32'hC0DE_0000 | (i * 32'h0101);
    forever begin
        @(negedge clk);
        wb_ack = 1'b0;
        wb_err = 1'b0;
        if (wb_stb) begin
            check_value("wb_adr", cur_addr, wb_adr);
            check_value("wb_we", cur_we, wb_we);
            check_value("wb_dat", cur_wdata, wb_dat_o);
            check_value("wb_sel", cur_sel, wb_sel);
            if (!busy) begin
                busy      = 1'b1;
                cnt       = (slow_wait >= 0) ? slow_wait : int'((lcg_next() >> 16) & 3);
                last_wait = cnt;
            end
        end
        if (busy && cnt == 0) begin
            busy = 1'b0;
            if ((wb_adr & ERR_MASK) == ERR_BASE) begin
                wb_err = 1'b1;
            end else begin
                wb_ack = 1'b1;
                for (int b = 0; b < 4; b++) begin
                    if (wb_we && wb_sel[b]) wb_mem[wb_adr[5:2]][8*b +: 8] = wb_dat_o[8*b +: 8];
                end
                wb_dat_i = wb_mem[wb_adr[5:2]];
            end
        end else if (busy) begin
            cnt--;
        end
    end
end

// ----------------------------------------------------------
// Step execution
// ----------------------------------------------------------
task automatic watch_count();
    mtime_t prev;
    prev = mtime;
    while (mtime < CMP_TARGET + 4) begin
        @(negedge clk);
        check_value("mtime_monotonic", 1, mtime >= prev);
        check_value("irq_vs_mtime", mtime >= CMP_TARGET, timer_irq);
        prev = mtime;
    end
    check_value("irq_raised", 1, timer_irq);
endtask

task automatic run_step(input step_t s);
    int   lat;
    logic to_tmr;
    to_tmr    = (s.sel == '0);   // Timer entries expect no Wishbone lanes
    cur_addr  = s.addr;
    cur_we    = (s.cmd == WR);
    cur_wdata = s.wdata;
    cur_sel   = s.sel;
    @(negedge clk);
    drive_req(s.cmd, s.width, s.addr, s.wdata);
    #1;
    while (!dmem_req_ack) begin   // Hold until accepted
        @(negedge clk);
        #1;
    end
    @(negedge clk);
    dmem_req = 1'b0;
    lat      = 1;
    #1;
    while (dmem_resp == MEM_RESP_NOTRDY) begin
        @(negedge clk);
        #1;
        lat++;
    end
    check_value({s.name, " resp"}, s.resp, dmem_resp);
    check_value({s.name, " latency"}, to_tmr ? 1 : 2 + last_wait, lat);
    if (s.cmd == RD && (s.resp == OK || to_tmr))
        check_value({s.name, " rdata"}, s.rdata, dmem_rdata);
    if (s.after == AFTER_COUNT) watch_count();
    if (s.after == AFTER_IRQ_LOW) check_value({s.name, " irq"}, 0, timer_irq);
endtask

// Second request waits behind a slow slave
task automatic check_backpressure();
    int held;
    held      = 0;
    slow_wait = 3;
    cur_addr  = 32'h0000_1010;
    cur_we    = 1'b1;
    cur_wdata = 32'h600D_F00D;
    cur_sel   = 4'hF;
    @(negedge clk);
    drive_req(WR, WD, 32'h0000_1010, 32'h600D_F00D);
    #1;
    check_value("bp_first_ack", 1, dmem_req_ack);
    @(negedge clk);
    drive_req(RD, WD, 32'h0000_1010, 32'h0);
    #1;
    while (dmem_resp == MEM_RESP_NOTRDY) begin
        check_value("bp_ack_held_low", 0, dmem_req_ack);
        held++;
        @(negedge clk);
        #1;
    end
    check_value("bp_held_cycles", 4, held);   // 2 + wait, minus the response cycle
    check_value("bp_first_resp", OK, dmem_resp);
    check_value("bp_ack_with_resp", 1, dmem_req_ack);
    cur_we    = 1'b0;
    cur_wdata = 32'h0;
    @(negedge clk);
    dmem_req = 1'b0;
    #1;
    while (dmem_resp == MEM_RESP_NOTRDY) begin
        @(negedge clk);
        #1;
    end
    check_value("bp_second_resp", OK, dmem_resp);
    check_value("bp_second_rdata", 32'h600D_F00D, dmem_rdata);
    slow_wait = -1;
endtask

// ----------------------------------------------------------
// Watchdog
// ----------------------------------------------------------
initial begin
    @(negedge rst);
    #((steps.size() + 2) * CYCLES_PER_STEP * CLK_PERIOD);
    $display("Timeout: the DUT did not finish the tests in time");
    $display("Test failed");
    $fatal(1);
end

// ----------------------------------------------------------
// Main sequence
// ----------------------------------------------------------
initial begin
    rst = 1'b1;
    dmem_req = 1'b0;
    drive_req(RD, WD, '0, '0);
    dmem_req = 1'b0;
    // Timer registers and errors
    add_step("div_wr",     WR, WD, TMR + `TIMER_OFS_DIV,    32'h0000_03A5, 4'h0, OK, 0, 0);
    add_step("div_rd",     RD, WD, TMR + `TIMER_OFS_DIV,    32'h0,   4'h0, OK, 32'h0000_03A5, 0);
    add_step("cmplo_wr",   WR, WD, TMR + `TIMER_OFS_CMP_LO, 32'h1234_5678, 4'h0, OK, 0, 0);
    add_step("cmplo_rd",   RD, WD, TMR + `TIMER_OFS_CMP_LO, 32'h0,   4'h0, OK, 32'h1234_5678, 0);
    add_step("cmphi_wr",   WR, WD, TMR + `TIMER_OFS_CMP_HI, 32'h0000_00AB, 4'h0, OK, 0, 0);
    add_step("cmphi_rd",   RD, WD, TMR + `TIMER_OFS_CMP_HI, 32'h0,   4'h0, OK, 32'h0000_00AB, 0);
    add_step("ctrl_wr",    WR, WD, TMR + `TIMER_OFS_CTRL,   32'hFFFF_FFFE, 4'h0, OK, 0, 0);
    add_step("byte_er",    WR, BY, TMR + `TIMER_OFS_CTRL,   32'h0000_0001, 4'h0, ER, 0, 0);
    add_step("ctrl_rd",    RD, WD, TMR + `TIMER_OFS_CTRL,   32'h0,   4'h0, OK, 32'h0, 0);
    add_step("hole_er",    RD, WD, TMR + 32'h18,            32'h0,   4'h0, ER, 32'h0, 0);
    // Counting and interrupt
    add_step("div_zero",   WR, WD, TMR + `TIMER_OFS_DIV,    32'h0,   4'h0, OK, 0, 0);
    add_step("cmphi_zero", WR, WD, TMR + `TIMER_OFS_CMP_HI, 32'h0,   4'h0, OK, 0, 0);
    add_step("cmplo_20",   WR, WD, TMR + `TIMER_OFS_CMP_LO, 32'd20,  4'h0, OK, 0, 0);
    add_step("ctrl_en",    WR, WD, TMR + `TIMER_OFS_CTRL,   32'h1,   4'h0, OK, 0, AFTER_COUNT);
    add_step("cmphi_one",  WR, WD, TMR + `TIMER_OFS_CMP_HI, 32'h1,   4'h0, OK, 0, AFTER_IRQ_LOW);
    add_step("ctrl_rd_on", RD, WD, TMR + `TIMER_OFS_CTRL,   32'h0,   4'h0, OK, 32'h1, 0);
    // Wishbone lanes, fill is C0DE0000 | index * 0101
    add_step("wb_wr_word", WR, WD, 32'h0000_1000, 32'hDEAD_BEEF, 4'hF, OK, 0, 0);
    add_step("wb_rd_word", RD, WD, 32'h0000_1000, 32'h0,         4'hF, OK, 32'hDEAD_BEEF, 0);
    add_step("wb_wr_byte", WR, BY, 32'h0000_1006, 32'h1122_3344, 4'h4, OK, 0, 0);
    add_step("wb_wr_hwhi", WR, HW, 32'h0000_100A, 32'h5566_7788, 4'hC, OK, 0, 0);
    add_step("wb_wr_hwlo", WR, HW, 32'h0000_1008, 32'h99AA_BBCC, 4'h3, OK, 0, 0);
    add_step("wb_rd_byte", RD, BY, 32'h0000_1007, 32'h0,         4'h8, OK, 32'hC022_0101, 0);
    add_step("wb_rd_hw",   RD, HW, 32'h0000_1008, 32'h0,         4'h3, OK, 32'h5566_BBCC, 0);
    add_step("wb_rd_fill", RD, WD, 32'h0000_103C, 32'h0,         4'hF, OK, 32'hC0DE_0F0F, 0);
    add_step("wb_rd_err",  RD, WD, 32'hE000_0010, 32'h0,         4'hF, ER, 0, 0);
    add_step("wb_wr_err",  WR, BY, 32'hE000_0001, 32'h0000_5A00, 4'h2, ER, 0, 0);

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    check_value("reset_ack", 1, dmem_req_ack);
    check_value("reset_resp", MEM_RESP_NOTRDY, dmem_resp);
    check_value("reset_stb", 0, wb_stb);
    check_value("reset_we", 0, wb_we);
    check_value("reset_irq", 0, timer_irq);
    check_value("reset_mtime", 0, mtime);

    foreach (steps[i]) run_step(steps[i]);
    check_backpressure();

    repeat (2) @(negedge clk);
    $display("Test passed");
    $finish;
end

endmodule : tb_dmem_subsys

/* vlog.f */
+incdir+hdl
hdl/dmem_if_pkg.sv
hdl/wb_pkg.sv
hdl/dmem_router.sv
hdl/mtimer.sv
hdl/dmem_wb_bridge.sv
hdl/dmem_subsys_top.sv
tb/tb_dmem_subsys.sv
